// File: tb.f
chip_pkg.sv
tempo_timer.sv
step_sequencer.sv
tone_divider.sv
square_channel.sv
triangle_channel.sv
noise_channel.sv
audio_mixer.sv
chip_top.sv
tb_chip.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_chip -o vsim
out=$(./obj_dir/vsim)
echo "$out"
if echo "$out" | grep -qx "All tests passed"; then
	exit 0
else
	exit 1
fi

// File: tb_chip.sv
`timescale 1ns/1ns

module tb_chip import chip_pkg::*;;

	localparam int TICK_DIV = 50;
	localparam int STEP_DIV = 4000;
	localparam int CLK_NS = 4;
	// about 34 steps of tests plus margin
	localparam int WATCH_NS = 40 * STEP_DIV * CLK_NS;

	logic       clk;
	logic       rst_n;
	chan_en_t   chan_en;
	fx_ctrl_t   fx_ctrl;
	vol_t       vol;
	logic       restart;
	logic [7:0] audio_out;
	logic       beat_led;

	// state of the output monitor
	int mode, errors, test_err, pass_cnt, fail_cnt, cyc, c0;
	int step_no, since, prev, vol_d, rmax, cs, per, run_len, run_step, run_since;
	int sq_runs, last_p, found_n, pn, lvl;
	logic beat_q, tog, pend, run_ok, got, restart_d, hit, shifted;
	logic [14:0] lfsr;
	fx_ctrl_t fx_cfg;

	chip_top #(.TICK_DIV(TICK_DIV), .STEP_DIV(STEP_DIV)) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.chan_en   (chan_en),
		.fx_ctrl   (fx_ctrl),
		.vol       (vol),
		.restart   (restart),
		.audio_out (audio_out),
		.beat_led  (beat_led)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCH_NS);
		$display("timeout: the DUT stopped stepping, run aborted");
		$display("Some tests failed");
		$finish;
	end

	task automatic check(input bit ok, input string what);
		assert (ok)
		else
		begin
			$display("mismatch at %0t ns: %s", $time, what);
			errors++;
			test_err++;
		end
	endtask

	// step period of a note from the package table
	function automatic int note_period(input int n);
		return int'(period_table[(n - 1) % 12]) >> ((n - 1) / 12);
	endfunction

	function automatic int scale(input int s, input int v);
		case (v)
			0: return s * 4;
			1: return s * 2;
			2: return s;
			default: return s / 2;
		endcase
	endfunction

	// high phases out of 8 per duty select
	function automatic int high_phases(input int sel);
		case (sel)
			0: return 1;
			1: return 2;
			2: return 4;
			default: return 6;
		endcase
	endfunction

	task automatic wait_steps(input int n);
		repeat (n) @(beat_led);
	endtask

	// hold restart with voices off and release into step 0
	task automatic start_pattern(input chan_en_t en, input fx_ctrl_t fx, input vol_t v,
		input int m);
		@(posedge clk);
		mode = 0;
		chan_en <= '0;
		fx_ctrl <= fx;
		vol <= v;
		restart <= 1'b1;
		repeat (8) @(posedge clk);
		restart <= 1'b0;
		chan_en <= en;
		cs = 0;
		per = note_period(seq_pattern[0].noise_note);
		lfsr = '1;
		shifted = 1'b0;
		pend = 1'b0;
		got = 1'b0;
		last_p = 255;
		sq_runs = 0;
		rmax = 0;
		mode = m;
	endtask

	task automatic report(input string name);
		if (test_err == 0)
			pass_cnt++;
		else
			fail_cnt++;
		$display("test %-22s %s (%0d errors)", name, test_err == 0 ? "PASS" : "FAIL", test_err);
		test_err = 0;
	endtask

	always @(negedge clk)
		cyc++;

	// output checks sampled mid-cycle
	always @(negedge clk)
	begin
		tog = (beat_led != beat_q);
		beat_q = beat_led;
		if (tog)
		begin
			step_no++;
			since = 0;
		end
		else
			since++;
		if (restart)
			step_no = 0;
		if (restart_d)
			check(beat_led == 1'b0, "beat_led set while restart held");
		if (mode == 1)
			check(audio_out == 8'd0, "audio with every voice disabled");
		// every triangle sample must be a scaled level
		if (mode == 4 || mode == 7)
		begin
			hit = 1'b0;
			for (lvl = 0; lvl < 16; lvl++)
				if (scale(lvl, vol_d) == int'(audio_out))
					hit = 1'b1;
			check(hit, $sformatf("audio %0d not a level at vol %0d", audio_out, vol_d));
		end
		if (mode == 4 && int'(audio_out) != prev)
		begin
			check(int'(audio_out) - prev == 1 || prev - int'(audio_out) == 1, "ramp jumped");
			if (int'(audio_out) > rmax)
				rmax = audio_out;
			// end of one full ramp
			if (audio_out == 8'd0)
			begin
				check(rmax == 15, $sformatf("ramp peaked at %0d", rmax));
				rmax = 0;
			end
		end
		// strobe k of a step reaches audio k periods plus two clocks in
		if (mode == 5)
		begin
			cs++;
			if (cs > 2 && (cs - 2) % per == 0)
			begin
				lfsr = {lfsr[13:0], lfsr[14] ^ lfsr[13]};
				shifted = 1'b1;
			end
			// level stays 0 until the first strobe after enable
			check(int'(audio_out) == ((shifted && lfsr[0]) ? 15 : 0),
				"noise sample off the LFSR model");
			if (pend)
			begin
				cs = 1;
				per = note_period(seq_pattern[step_no % 16].noise_note);
			end
			pend = tog;
		end
		// square runs of level 15
		if (audio_out == 8'd15 && prev != 15)
		begin
			run_len = 1;
			run_step = step_no;
			run_since = since;
			run_ok = !restart && (mode == 3 || mode == 6);
			if (mode == 3 && since > 1)
				check(seq_pattern[step_no % 16].sq_gate, "square high in a gated-off step");
		end
		else if (audio_out == 8'd15)
			run_len++;
		else if (prev == 15 && run_ok && run_step == step_no)
		begin
			pn = note_period(seq_pattern[step_no % 16].sq_note);
			if (mode == 3)
			begin
				check(run_len == high_phases(fx_ctrl.fx_opt.sq.duty_sel) * pn,
					$sformatf("square run %0d clocks, period %0d", run_len, pn));
				sq_runs++;
			end
			else if (mode == 6 && step_no == 2)
			begin
				found_n = 0;
				for (lvl = seq_pattern[1].sq_note; lvl <= seq_pattern[2].sq_note; lvl++)
					if (4 * note_period(lvl) == run_len)
						found_n = lvl;
				if (found_n != 0)
				begin
					check(note_period(found_n) <= last_p, "glide moved away from the target");
					last_p = note_period(found_n);
					if (found_n == seq_pattern[2].sq_note && !got)
					begin
						got = 1'b1;
						// glide ticks plus one full wave cycle to line up
						check(run_since <= 2 * 5 * TICK_DIV + 8 * pn + 4, "glide too slow");
					end
				end
				else
				begin
					check(!got, "run off the target after the glide ended");
					check(run_len >= 4 * pn && run_len <= 5 * note_period(41) + 2,
						$sformatf("glide run of %0d clocks out of range", run_len));
				end
			end
		end
		prev = audio_out;
		vol_d = vol;
		restart_d = restart;
	end

	initial
	begin
		void'($urandom(32'h2e79fe8d));
		rst_n = 1'b0;
		chan_en = '0;
		fx_ctrl = '0;
		vol = 2'd2;
		restart = 1'b0;
		fx_cfg = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check(audio_out == 8'd0 && beat_led == 1'b0, "outputs not clear after reset");
		@(posedge clk);
		mode = 1;
		wait_steps(2);
		mode = 0;
		report("reset and silence");

		// toggle spacing then restart hold and release
		@(beat_led);
		c0 = cyc;
		repeat (2)
		begin
			@(beat_led);
			check(cyc - c0 == STEP_DIV, $sformatf("step took %0d clocks", cyc - c0));
			c0 = cyc;
		end
		@(posedge clk);
		restart <= 1'b1;
		repeat (20) @(posedge clk);
		restart <= 1'b0;
		c0 = cyc;
		@(beat_led);
		check(cyc - c0 == STEP_DIV, $sformatf("first step after restart %0d", cyc - c0));
		report("step rate and restart");

		for (int s = 0; s < 4; s++)
		begin
			fx_cfg.fx_mode = 2'd0;
			fx_cfg.fx_opt.sq.spare = 2'd0;
			fx_cfg.fx_opt.sq.duty_sel = 2'(s);
			start_pattern(4'b0001, fx_cfg, 2'd2, 3);
			wait_steps(4);
			check(sq_runs > 0, "no complete square run was seen");
		end
		report("square pitch and duty");

		start_pattern(4'b0100, '0, 2'd2, 4);
		wait_steps(3);
		mode = 7;
		repeat (2 * STEP_DIV / 40)
		begin
			@(posedge clk);
			vol <= vol_t'($urandom_range(3, 0));
			repeat (39) @(posedge clk);
		end
		report("volume scaling");

		start_pattern(4'b1000, '0, 2'd2, 5);
		wait_steps(4);
		report("noise sequence");

		fx_cfg.fx_mode = 2'd1;
		fx_cfg.fx_opt.glide_rate = 4'd2;
		start_pattern(4'b0001, fx_cfg, 2'd2, 6);
		wait_steps(3);
		check(got, "glide never reached the target pitch");
		mode = 0;
		report("portamento");

		$display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, errors);
		if (fail_cnt == 0 && errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: chip_top.sv
`timescale 1ns/1ns

module chip_top import chip_pkg::*; #(
	parameter int TICK_DIV = 50,
	parameter int STEP_DIV = 4000
) (
	input  logic       clk,
	input  logic       rst_n,
	input  chan_en_t   chan_en,
	input  fx_ctrl_t   fx_ctrl,
	input  vol_t       vol,
	input  logic       restart,
	output logic [7:0] audio_out,
	output logic       beat_led
);

	logic   fx_tick;
	logic   step_tick;
	step_t  cur_step;
	level_t sq_level;
	level_t tri_level;
	level_t noise_level;

	tempo_timer #(
		.TICK_DIV (TICK_DIV),
		.STEP_DIV (STEP_DIV)
	) i_tempo (
		.clk       (clk),
		.rst_n     (rst_n),
		.restart   (restart),
		.fx_tick   (fx_tick),
		.step_tick (step_tick)
	);

	step_sequencer i_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.step_tick (step_tick),
		.restart   (restart),
		.cur_step  (cur_step),
		.beat_led  (beat_led)
	);

	// step gate and enable both open the square voice
	square_channel i_sq (
		.clk         (clk),
		.rst_n       (rst_n),
		.target_note (cur_step.sq_note),
		.gate        (cur_step.sq_gate & chan_en[0]),
		.fx_tick     (fx_tick),
		.fx_ctrl     (fx_ctrl),
		.level       (sq_level)
	);

	// enable bit 1 stays reserved
	triangle_channel i_tri (
		.clk   (clk),
		.rst_n (rst_n),
		.note  (cur_step.tri_note),
		.run   (chan_en[2]),
		.level (tri_level)
	);

	noise_channel i_noise (
		.clk   (clk),
		.rst_n (rst_n),
		.note  (cur_step.noise_note),
		.run   (chan_en[3]),
		.level (noise_level)
	);

	audio_mixer i_mix (
		.clk         (clk),
		.rst_n       (rst_n),
		.sq_level    (sq_level),
		.tri_level   (tri_level),
		.noise_level (noise_level),
		.vol         (vol),
		.audio_out   (audio_out)
	);

endmodule

// File: audio_mixer.sv
`timescale 1ns/1ns

module audio_mixer import chip_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  level_t     sq_level,
	input  level_t     tri_level,
	input  level_t     noise_level,
	input  vol_t       vol,
	output logic [7:0] audio_out
);

	// fourth slot kept for the missing second square voice
	level_t     rsv_level;
	logic [5:0] sum;
	logic [7:0] scaled;

	assign rsv_level = '0;

	// widened so four full levels do not wrap
	assign sum = 6'(sq_level) + 6'(tri_level) + 6'(noise_level) + 6'(rsv_level);

	always_comb
	begin
		case (vol)
			2'd0: scaled = {sum, 2'b00};
			2'd1: scaled = {1'b0, sum, 1'b0};
			2'd2: scaled = {2'b00, sum};
			default: scaled = {3'b000, sum[5:1]};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			audio_out <= 8'd0;
		else
			audio_out <= scaled;
	end

endmodule

// File: noise_channel.sv
`timescale 1ns/1ns

module noise_channel import chip_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  note_t  note,
	input  logic   run,
	output level_t level
);

	logic [14:0] lfsr;
	logic [14:0] lfsr_next;
	logic        strobe;

	// taps 14 and 13, new bit in at the bottom
	assign lfsr_next = {lfsr[13:0], lfsr[14] ^ lfsr[13]};

	tone_divider i_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.note   (note),
		.run    (run),
		.strobe (strobe)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			lfsr  <= '1;
			level <= '0;
		end
		else if (!run || note == '0)
		begin
			// reseed so every note starts the same sequence
			lfsr  <= '1;
			level <= '0;
		end
		else if (strobe)
		begin
			lfsr  <= lfsr_next;
			level <= lfsr_next[0] ? 4'd15 : 4'd0;
		end
	end

endmodule

// File: triangle_channel.sv
`timescale 1ns/1ns

module triangle_channel import chip_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  note_t  note,
	input  logic   run,
	output level_t level
);

	// 32 phases, top bit picks the falling half
	logic [4:0] phase;
	logic [4:0] phase_next;
	logic       strobe;

	assign phase_next = phase + 5'd1;

	tone_divider i_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.note   (note),
		.run    (run),
		.strobe (strobe)
	);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 5'd0;
			level <= '0;
		end
		else if (!run || note == '0)
		begin
			phase <= 5'd0;
			level <= '0;
		end
		else if (strobe)
		begin
			phase <= phase_next;
			// ramp up 0..15, then mirror down 15..0
			level <= phase_next[4] ? ~phase_next[3:0] : phase_next[3:0];
		end
	end

endmodule

// File: square_channel.sv
`timescale 1ns/1ns

module square_channel import chip_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  note_t    target_note,
	input  logic     gate,
	input  logic     fx_tick,
	input  fx_ctrl_t fx_ctrl,
	output level_t   level
);

	fx_ctrl_t   fx_q;
	// note actually sounding, trails target in portamento
	note_t      cur_note;
	logic [3:0] glide_cnt;
	logic [3:0] glide_max;
	logic       porta;
	logic [3:0] duty;
	logic [2:0] phase;
	logic       strobe;

	assign porta = (fx_q.fx_mode == 2'd1);
	// rate 0 counts as 1 tick per semitone
	assign glide_max = (fx_q.fx_opt.glide_rate == 4'd0) ? 4'd0 : fx_q.fx_opt.glide_rate - 4'd1;
	// option bits are a glide rate in portamento, so fixed half duty there
	assign duty = porta ? 4'd4 : duty_len(fx_q.fx_opt.sq.duty_sel);

	tone_divider i_div (
		.clk    (clk),
		.rst_n  (rst_n),
		.note   (cur_note),
		.run    (gate),
		.strobe (strobe)
	);

	// effect control and sounding note
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fx_q      <= '0;
			cur_note  <= '0;
			glide_cnt <= 4'd0;
		end
		else
		begin
			fx_q <= fx_ctrl;
			if (!porta || target_note == '0 || cur_note == '0)
			begin
				// plain mode, rests and first note jump straight there
				cur_note  <= target_note;
				glide_cnt <= 4'd0;
			end
			else if (cur_note == target_note)
				glide_cnt <= 4'd0;
			else if (fx_tick)
			begin
				if (glide_cnt >= glide_max)
				begin
					glide_cnt <= 4'd0;
					// one semitone toward the target
					if (cur_note < target_note)
						cur_note <= cur_note + 6'd1;
					else
						cur_note <= cur_note - 6'd1;
				end
				else
					glide_cnt <= glide_cnt + 4'd1;
			end
		end
	end

	// 8-phase wave
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 3'd0;
			level <= '0;
		end
		else if (!gate || cur_note == '0)
		begin
			phase <= 3'd0;
			level <= '0;
		end
		else if (strobe)
		begin
			phase <= phase + 3'd1;
			level <= ({1'b0, phase} < duty) ? 4'd15 : 4'd0;
		end
	end

endmodule

// File: tone_divider.sv
`timescale 1ns/1ns

module tone_divider import chip_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  note_t note,
	input  logic  run,
	output logic  strobe
);

	note_t      note_m1;
	logic [3:0] semi;
	logic [2:0] oct;
	logic [7:0] period;
	// last note seen, to spot a change
	note_t      note_q;
	logic [7:0] cnt;
	logic       active;

	// semitone and octave of note-1
	assign note_m1 = note - 6'd1;
	assign semi    = 4'(note_m1 % 6'd12);
	assign oct     = 3'(note_m1 / 6'd12);
	// one octave up halves the period
	assign period  = period_table[semi] >> oct;

	assign active = run && (note != '0) && (note == note_q);
	assign strobe = active && (cnt == period - 8'd1);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			note_q <= '0;
			cnt    <= 8'd0;
		end
		else
		begin
			note_q <= note;
			// held at zero when silent or on a new note
			if (!active)
				cnt <= 8'd0;
			else if (strobe)
				cnt <= 8'd0;
			else
				cnt <= cnt + 8'd1;
		end
	end

endmodule

// File: step_sequencer.sv
`timescale 1ns/1ns

module step_sequencer import chip_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  step_tick,
	input  logic  restart,
	output step_t cur_step,
	output logic  beat_led
);

	// position in the 16-step pattern
	logic [3:0] idx;
	logic [3:0] idx_next;

	// wraps from 15 back to 0 by width
	assign idx_next = idx + 4'd1;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			idx      <= 4'd0;
			cur_step <= seq_pattern[0];
			beat_led <= 1'b0;
		end
		else if (restart)
		begin
			// hold at the top of the pattern
			idx      <= 4'd0;
			cur_step <= seq_pattern[0];
			beat_led <= 1'b0;
		end
		else if (step_tick)
		begin
			idx      <= idx_next;
			// cur_step always mirrors the entry at idx
			cur_step <= seq_pattern[idx_next];
			// blink once per step
			beat_led <= ~beat_led;
		end
	end

endmodule

// File: tempo_timer.sv
`timescale 1ns/1ns

module tempo_timer #(
	parameter int TICK_DIV = 50,
	parameter int STEP_DIV = 4000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic restart,
	output logic fx_tick,
	output logic step_tick
);

	localparam int TW = $clog2(TICK_DIV + 1);
	localparam int SW = $clog2(STEP_DIV + 1);

	logic [TW-1:0] tick_cnt;
	logic [SW-1:0] step_cnt;

	// one-cycle pulses on the last count of each divider
	assign fx_tick   = (tick_cnt == TW'(TICK_DIV - 1));
	assign step_tick = (step_cnt == SW'(STEP_DIV - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			tick_cnt <= '0;
			step_cnt <= '0;
		end
		else if (restart)
		begin
			// both rates start over from the restart edge
			tick_cnt <= '0;
			step_cnt <= '0;
		end
		else
		begin
			// effect rate
			if (fx_tick)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
			// step rate
			if (step_tick)
				step_cnt <= '0;
			else
				step_cnt <= step_cnt + 1'b1;
		end
	end

endmodule

// File: chip_pkg.sv
package chip_pkg;

	// note index, 0 is a rest, 1..63 are semitones
	typedef logic [5:0] note_t;

	// per-voice output level
	typedef logic [3:0] level_t;

	// mixer volume select
	typedef logic [1:0] vol_t;

	// voice enables: 0 square, 1 reserved, 2 triangle, 3 noise
	typedef logic [3:0] chan_en_t;

	// effect option, duty select in plain mode, glide rate in portamento
	typedef union packed {
		struct packed {
			logic [1:0] spare;
			logic [1:0] duty_sel;
		} sq;
		logic [3:0] glide_rate;
	} fx_opt_u;

	typedef struct packed {
		logic [1:0] fx_mode;
		fx_opt_u    fx_opt;
	} fx_ctrl_t;

	// one sequencer step
	typedef struct packed {
		note_t sq_note;
		logic  sq_gate;
		note_t tri_note;
		note_t noise_note;
	} step_t;

	// step periods in clocks, octave 0, shifted right per octave
	localparam logic [7:0] period_table [12] = '{
		8'd120, 8'd113, 8'd107, 8'd101, 8'd95, 8'd90,
		8'd85, 8'd80, 8'd76, 8'd72, 8'd68, 8'd64
	};

	// sq_note, sq_gate, tri_note, noise_note
	localparam step_t seq_pattern [16] = '{
		'{6'd41, 1'b1, 6'd1, 6'd49},
		'{6'd41, 1'b0, 6'd13, 6'd57},
		'{6'd46, 1'b1, 6'd25, 6'd61},
		'{6'd46, 1'b0, 6'd1, 6'd53},
		'{6'd44, 1'b1, 6'd13, 6'd49},
		'{6'd44, 1'b0, 6'd25, 6'd57},
		'{6'd37, 1'b1, 6'd1, 6'd61},
		'{6'd37, 1'b0, 6'd13, 6'd53},
		'{6'd37, 1'b1, 6'd25, 6'd49},
		'{6'd37, 1'b0, 6'd1, 6'd57},
		'{6'd39, 1'b1, 6'd13, 6'd61},
		'{6'd41, 1'b0, 6'd25, 6'd53},
		'{6'd39, 1'b1, 6'd1, 6'd49},
		'{6'd39, 1'b0, 6'd13, 6'd57},
		'{6'd51, 1'b1, 6'd25, 6'd61},
		'{6'd51, 1'b0, 6'd1, 6'd53}
	};

	// high phases out of 8 for each duty select
	function automatic logic [3:0] duty_len(input logic [1:0] duty_sel);
		case (duty_sel)
			2'd0: return 4'd1;
			2'd1: return 4'd2;
			2'd2: return 4'd4;
			default: return 4'd6;
		endcase
	endfunction

endpackage
